//--- hw/sp_defs.svh
// shared constants for the series processor
// modulus, series length, word widths and inverse exponent

`ifndef SP_DEFS_SVH
`define SP_DEFS_SVH

// field modulus, GF(509)
`define SP_MOD 509

// elements per series
`define SP_LEN 6

// residue, raw product and accumulator widths
`define SP_W 9
`define SP_PROD_W 18
// three residues fit in 11 bits
`define SP_ACC_W 11

// Fermat inverse, x^(p-2)
`define SP_INV_EXP 9'd507

`endif

//--- hw/sp_pkg.sv
// shared types for the series processor
// residue and product words, mode bits, series stream beat

`include "sp_defs.svh"

package sp_pkg;

	// ==============================
	// word types
	// ==============================

	typedef logic [`SP_W-1:0] residue_t;

	typedef logic [`SP_PROD_W-1:0] product_t;

	// ==============================
	// control and stream types
	// ==============================

	typedef struct packed {
		logic inv_en;
		logic sort_en;
	} sp_mode_t;

	// one element of a series stream
	typedef struct packed {
		logic     valid;
		residue_t data;
	} series_beat_t;

endpackage

//--- hw/mod509_reduce.sv
// combinational reduction of an 18-bit value mod 509
// fold by 512 = 3 (mod 509), then trim by a multiple of 509

`timescale 1ns/100ps
`include "sp_defs.svh"

module mod509_reduce
	import sp_pkg::*;
(
	input  product_t value,
	output residue_t residue
);

	localparam int FOLD_W = `SP_W + 2;
	localparam logic [FOLD_W-1:0] MOD_X1 = FOLD_W'(`SP_MOD);
	localparam logic [FOLD_W-1:0] MOD_X2 = FOLD_W'(2 * `SP_MOD);
	localparam logic [FOLD_W-1:0] MOD_X3 = FOLD_W'(3 * `SP_MOD);
	localparam logic [FOLD_W-1:0] MOD_X4 = FOLD_W'(4 * `SP_MOD);

	logic [`SP_W-1:0] hi_part;
	logic [FOLD_W-1:0] folded;
	logic [FOLD_W-1:0] trimmed;

	assign hi_part = value[`SP_PROD_W-1:`SP_W];

	// low + 3*high, at most 2044
	assign folded = FOLD_W'(value[`SP_W-1:0]) + FOLD_W'(hi_part) + {1'b0, hi_part, 1'b0};

	always_comb begin
		if (folded >= MOD_X4)
			trimmed = folded - MOD_X4;
		else if (folded >= MOD_X3)
			trimmed = folded - MOD_X3;
		else if (folded >= MOD_X2)
			trimmed = folded - MOD_X2;
		else if (folded >= MOD_X1)
			trimmed = folded - MOD_X1;
		else
			trimmed = folded;
	end

	assign residue = trimmed[`SP_W-1:0];

endmodule

//--- hw/mod_inverse.sv
// modular inverse stage for one series
// collects six elements, raises each to 507 by serial
// square-and-multiply, then streams the results out in order

`timescale 1ns/100ps
`include "sp_defs.svh"

module mod_inverse
	import sp_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  series_beat_t in_beat,
	output series_beat_t out_beat
);

	localparam logic [1:0] ST_COLLECT = 2'd0;
	localparam logic [1:0] ST_COMPUTE = 2'd1;
	localparam logic [1:0] ST_EMIT    = 2'd2;

	localparam int BIT_W = $clog2(`SP_W);
	localparam logic [2:0] LAST_IDX = 3'(`SP_LEN - 1);
	localparam logic [BIT_W-1:0] TOP_BIT = BIT_W'(`SP_W - 1);
	localparam logic [`SP_W-1:0] INV_EXP = `SP_INV_EXP;

	logic [1:0] state;
	logic [2:0] idx;
	logic [BIT_W-1:0] bit_cnt;
	logic mul_phase;
	logic elem_done;
	logic emit;

	residue_t elem [0:`SP_LEN-1];
	residue_t acc;
	residue_t mul_op;
	residue_t prod_mod;
	residue_t acc_next;
	product_t prod;

	// ==============================
	// multiply-reduce datapath
	// ==============================

	// even cycle squares, odd cycle multiplies by the base
	assign mul_op = mul_phase ? elem[idx] : acc;
	assign prod = product_t'(acc) * product_t'(mul_op);

	mod509_reduce reduce_inst (
		.value   (prod),
		.residue (prod_mod)
	);

	// multiply result kept only on a set exponent bit
	assign acc_next = (!mul_phase || INV_EXP[bit_cnt]) ? prod_mod : acc;
	assign elem_done = mul_phase && (bit_cnt == '0);

	// ==============================
	// control
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_COLLECT;
			idx <= '0;
			bit_cnt <= TOP_BIT;
			mul_phase <= 1'b0;
		end else begin
			case (state)
				ST_COLLECT: begin
					if (in_beat.valid) begin
						idx <= (idx == LAST_IDX) ? '0 : idx + 3'd1;
						if (idx == LAST_IDX)
							state <= ST_COMPUTE;
					end
				end
				ST_COMPUTE: begin
					mul_phase <= !mul_phase;
					if (mul_phase)
						bit_cnt <= bit_cnt - BIT_W'(1);
					if (elem_done) begin
						bit_cnt <= TOP_BIT;
						idx <= (idx == LAST_IDX) ? '0 : idx + 3'd1;
						if (idx == LAST_IDX)
							state <= ST_EMIT;
					end
				end
				ST_EMIT: begin
					idx <= (idx == LAST_IDX) ? '0 : idx + 3'd1;
					if (idx == LAST_IDX)
						state <= ST_COLLECT;
				end
				default: state <= ST_COLLECT;
			endcase
		end
	end

	// result overwrites its base in the element store
	always_ff @(posedge clk) begin
		if (state == ST_COLLECT && in_beat.valid)
			elem[idx] <= in_beat.data;
		else if (state == ST_COMPUTE && elem_done)
			elem[idx] <= acc_next;

		// restart at 1 for each element
		if (state != ST_COMPUTE || elem_done)
			acc <= `SP_W'(1);
		else
			acc <= acc_next;
	end

	assign emit = (state == ST_EMIT);
	assign out_beat = '{valid: emit, data: emit ? elem[idx] : '0};

endmodule

//--- hw/series_sorter.sv
// descending sort stage for one series
// sorted insertion on arrival, one settle cycle, then shift-out
// from the largest entry

`timescale 1ns/100ps
`include "sp_defs.svh"

module series_sorter
	import sp_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  series_beat_t in_beat,
	output series_beat_t out_beat
);

	localparam logic [1:0] ST_FILL   = 2'd0;
	localparam logic [1:0] ST_SETTLE = 2'd1;
	localparam logic [1:0] ST_DRAIN  = 2'd2;
	localparam logic [2:0] LAST_CNT = 3'(`SP_LEN - 1);

	logic [1:0] state;
	logic [2:0] cnt;
	logic [`SP_LEN-1:0] ge;
	logic drain;
	residue_t ent [0:`SP_LEN-1];

	// new value against every held entry at once
	always_comb begin
		for (int i = 0; i < `SP_LEN; i++)
			ge[i] = (in_beat.data >= ent[i]);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_FILL;
			cnt <= '0;
		end else begin
			case (state)
				ST_FILL: begin
					if (in_beat.valid) begin
						cnt <= (cnt == LAST_CNT) ? '0 : cnt + 3'd1;
						if (cnt == LAST_CNT)
							state <= ST_SETTLE;
					end
				end
				ST_SETTLE: state <= ST_DRAIN;
				ST_DRAIN: begin
					cnt <= (cnt == LAST_CNT) ? '0 : cnt + 3'd1;
					if (cnt == LAST_CNT)
						state <= ST_FILL;
				end
				default: state <= ST_FILL;
			endcase
		end
	end

	// empty slots hold zero so any value lands ahead of them
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `SP_LEN; i++)
				ent[i] <= '0;
		end else if (state == ST_FILL && in_beat.valid) begin
			if (ge[0])
				ent[0] <= in_beat.data;
			for (int i = 1; i < `SP_LEN; i++) begin
				if (ge[i])
					ent[i] <= ge[i-1] ? ent[i-1] : in_beat.data;
			end
		end else if (drain) begin
			for (int i = 0; i < `SP_LEN - 1; i++)
				ent[i] <= (cnt == LAST_CNT) ? '0 : ent[i+1];
			ent[`SP_LEN-1] <= '0;
		end
	end

	assign drain = (state == ST_DRAIN);
	assign out_beat = '{valid: drain, data: drain ? ent[0] : '0};

endmodule

//--- hw/sp_top.sv
// series processor top level
// sequencer FSM, series buffer and accumulators, routes the series
// through the inverse and sort stages and emits the reduced sums

`timescale 1ns/100ps
`include "sp_defs.svh"

module sp_top
	import sp_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  series_beat_t in_beat,
	input  sp_mode_t     in_mode,
	output series_beat_t out_beat
);

	localparam logic [2:0] ST_COLLECT   = 3'd0;
	localparam logic [2:0] ST_FEED_INV  = 3'd1;
	localparam logic [2:0] ST_WAIT_INV  = 3'd2;
	localparam logic [2:0] ST_FEED_SORT = 3'd3;
	localparam logic [2:0] ST_WAIT_SORT = 3'd4;
	localparam logic [2:0] ST_EMIT      = 3'd5;
	localparam logic [2:0] LAST_POS = 3'(`SP_LEN - 1);

	logic [2:0] state;
	logic [2:0] state_next;
	logic [2:0] pos;
	sp_mode_t mode_r;

	logic step;
	logic last;
	logic add_en;
	logic buf_wr;
	logic inv_feed;
	logic sort_feed;
	logic emit;
	residue_t add_val;
	residue_t sum_mod;
	product_t sum_value;

	residue_t series_buf [0:`SP_LEN-1];
	logic [`SP_ACC_W-1:0] acc [0:`SP_LEN-1];

	series_beat_t inv_in;
	series_beat_t inv_out;
	series_beat_t sort_in;
	series_beat_t sort_out;

	// ==============================
	// source select per state
	// ==============================

	// a disabled stage replays the buffer into the sums
	always_comb begin
		step = 1'b0;
		add_en = 1'b0;
		buf_wr = 1'b0;
		add_val = '0;
		case (state)
			ST_COLLECT: begin
				step = in_beat.valid;
				add_en = in_beat.valid;
				buf_wr = in_beat.valid;
				add_val = in_beat.data;
			end
			ST_FEED_INV: begin
				step = 1'b1;
				add_en = !mode_r.inv_en;
				add_val = series_buf[pos];
			end
			ST_WAIT_INV: begin
				step = inv_out.valid;
				add_en = inv_out.valid;
				buf_wr = inv_out.valid;
				add_val = inv_out.data;
			end
			ST_FEED_SORT: begin
				step = 1'b1;
				add_en = !mode_r.sort_en;
				add_val = series_buf[pos];
			end
			ST_WAIT_SORT: begin
				step = sort_out.valid;
				add_en = sort_out.valid;
				buf_wr = sort_out.valid;
				add_val = sort_out.data;
			end
			ST_EMIT: step = 1'b1;
			default: step = 1'b0;
		endcase
	end

	assign last = step && (pos == LAST_POS);

	always_comb begin
		state_next = state;
		if (last) begin
			case (state)
				ST_COLLECT:   state_next = ST_FEED_INV;
				ST_FEED_INV:  state_next = mode_r.inv_en ? ST_WAIT_INV : ST_FEED_SORT;
				ST_WAIT_INV:  state_next = ST_FEED_SORT;
				ST_FEED_SORT: state_next = mode_r.sort_en ? ST_WAIT_SORT : ST_EMIT;
				ST_WAIT_SORT: state_next = ST_EMIT;
				default:      state_next = ST_COLLECT;
			endcase
		end
	end

	// ==============================
	// sequencer registers
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_COLLECT;
			pos <= '0;
			mode_r <= '0;
		end else begin
			state <= state_next;
			if (step)
				pos <= last ? '0 : pos + 3'd1;
			// mode taken with the first element
			if (state == ST_COLLECT && in_beat.valid && pos == '0)
				mode_r <= in_mode;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `SP_LEN; i++)
				acc[i] <= '0;
		end else if (state == ST_EMIT && last) begin
			for (int i = 0; i < `SP_LEN; i++)
				acc[i] <= '0;
		end else if (add_en) begin
			acc[pos] <= acc[pos] + `SP_ACC_W'(add_val);
		end
	end

	always_ff @(posedge clk) begin
		if (buf_wr)
			series_buf[pos] <= add_val;
	end

	// ==============================
	// stages and output
	// ==============================

	assign inv_feed = (state == ST_FEED_INV) && mode_r.inv_en;
	assign sort_feed = (state == ST_FEED_SORT) && mode_r.sort_en;
	assign inv_in = '{valid: inv_feed, data: inv_feed ? series_buf[pos] : '0};
	assign sort_in = '{valid: sort_feed, data: sort_feed ? series_buf[pos] : '0};

	mod_inverse inv_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_beat  (inv_in),
		.out_beat (inv_out)
	);

	series_sorter sort_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_beat  (sort_in),
		.out_beat (sort_out)
	);

	assign sum_value = product_t'(acc[pos]);

	mod509_reduce sum_reduce_inst (
		.value   (sum_value),
		.residue (sum_mod)
	);

	assign emit = (state == ST_EMIT);
	assign out_beat = '{valid: emit, data: emit ? sum_mod : '0};

endmodule

//--- bench/sp_tb_model.svh
// reference model and compare tasks for the series processor testbench
// expected residues from the series rule, typed result checks

`ifndef SP_TB_MODEL_SVH
`define SP_TB_MODEL_SVH

// one whole series, element k at index k
typedef residue_t [`SP_LEN-1:0] series_t;

// inverse by repeated multiplication, 0 stays 0
function automatic residue_t inv_ref(input residue_t x);
	int r;
	r = 1;
	for (int i = 0; i < `SP_MOD - 2; i++)
		r = (r * int'(x)) % `SP_MOD;
	return residue_t'(r);
endfunction

// plain bubble sort, largest first
function automatic series_t sort_desc(input series_t s);
	series_t t;
	residue_t tmp;
	t = s;
	for (int i = 0; i < `SP_LEN; i++) begin
		for (int j = 0; j < `SP_LEN - 1 - i; j++) begin
			if (t[j] < t[j+1]) begin
				tmp = t[j];
				t[j] = t[j+1];
				t[j+1] = tmp;
			end
		end
	end
	return t;
endfunction

// s0 + s1 + s2 per position, a skipped stage passes its input on
function automatic series_t expected_series(input series_t x, input sp_mode_t mode);
	series_t s1;
	series_t s2;
	series_t r;
	s1 = x;
	if (mode.inv_en) begin
		for (int k = 0; k < `SP_LEN; k++)
			s1[k] = inv_ref(x[k]);
	end
	s2 = mode.sort_en ? sort_desc(s1) : s1;
	for (int k = 0; k < `SP_LEN; k++)
		r[k] = residue_t'((int'(x[k]) + int'(s1[k]) + int'(s2[k])) % `SP_MOD);
	return r;
endfunction

task automatic check_residue(input residue_t got, input residue_t exp, input string what);
	if (got !== exp) begin
		$display("ERR %0t: %s, got %0d expected %0d", $time, what, got, exp);
		fail_run();
	end
endtask

task automatic check_beat_count(input int got, input int exp);
	if (got != exp) begin
		$display("ERR %0t: output run of %0d beats, expected %0d", $time, got, exp);
		fail_run();
	end
endtask

`endif

//--- bench/sp_tb.sv
// testbench for the series processor
// clock and reset, directed and random series, output scoreboard

`timescale 1ns/100ps
`include "sp_defs.svh"

module sp_tb
	import sp_pkg::*;
();

	localparam int RESET_CYCLES = 3;
	localparam int IDLE_CYCLES = 50;
	localparam int RUN_TIMEOUT = 2000;
	localparam int RANDOM_RUNS = 40;
	localparam int BUSY_BEATS = 12;

	logic clk;
	logic rst_n;
	series_beat_t in_beat;
	sp_mode_t in_mode;
	series_beat_t out_beat;

	`include "sp_tb_model.svh"

	// expected sums, one entry per series in flight
	series_t exp_q[$];
	int expected_runs = 0;
	int runs_done = 0;
	int run_beats = 0;

	sp_top sp_top_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_beat  (in_beat),
		.in_mode  (in_mode),
		.out_beat (out_beat)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_run();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// ==============================
	// scoreboard
	// ==============================

	// sampled on the falling edge, away from the DUT updates
	always @(negedge clk) begin
		if (out_beat.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("output beat at %0t while no series was pending", $time);
				fail_run();
			end else if (run_beats >= `SP_LEN) begin
				check_beat_count(run_beats + 1, `SP_LEN);
			end else begin
				check_residue(out_beat.data, exp_q[0][run_beats],
					$sformatf("series %0d element %0d", runs_done, run_beats));
				run_beats = run_beats + 1;
			end
		end else begin
			check_residue(out_beat.data, '0, "data while valid is low");
			// falling valid closes a run
			if (run_beats != 0) begin
				check_beat_count(run_beats, `SP_LEN);
				void'(exp_q.pop_front());
				runs_done = runs_done + 1;
				run_beats = 0;
			end
		end
	end

	// ==============================
	// stimulus helpers
	// ==============================

	function automatic series_t make_series(input int e0, input int e1, input int e2,
		input int e3, input int e4, input int e5);
		series_t s;
		s[0] = residue_t'(e0);
		s[1] = residue_t'(e1);
		s[2] = residue_t'(e2);
		s[3] = residue_t'(e3);
		s[4] = residue_t'(e4);
		s[5] = residue_t'(e5);
		return s;
	endfunction

	task automatic wait_run_done(input int target);
		int cycles;
		cycles = 0;
		while (runs_done < target) begin
			@(posedge clk);
			cycles++;
			if (cycles > RUN_TIMEOUT) begin
				$display("timeout: output series %0d missing after %0d cycles", target, cycles);
				fail_run();
			end
		end
	endtask

	// six beats, then optional junk beats while the DUT is busy
	task automatic drive_series(input series_t x, input sp_mode_t mode, input int extra);
		exp_q.push_back(expected_series(x, mode));
		expected_runs++;
		for (int k = 0; k < `SP_LEN; k++) begin
			@(posedge clk);
			in_beat <= '{valid: 1'b1, data: x[k]};
			in_mode <= mode;
		end
		for (int k = 0; k < extra; k++) begin
			@(posedge clk);
			in_beat <= '{valid: 1'b1, data: residue_t'($urandom_range(508))};
			in_mode <= sp_mode_t'(~mode);
		end
		@(posedge clk);
		in_beat <= '0;
		in_mode <= '0;
		wait_run_done(expected_runs);
	endtask

	// sanity of the model inverse, x * inv(x) = 1
	task automatic check_inverse_model(input series_t x);
		residue_t inv;
		for (int k = 0; k < `SP_LEN; k++) begin
			inv = inv_ref(x[k]);
			if (x[k] != '0)
				check_residue(residue_t'((int'(x[k]) * int'(inv)) % `SP_MOD),
					residue_t'(1), "model inverse times x");
		end
	endtask

	// ==============================
	// test sequence
	// ==============================

	initial begin
		series_t x;
		sp_mode_t mode;
		void'($urandom(71668));
		rst_n = 1'b0;
		in_beat = '0;
		in_mode = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		// quiet output after reset, scoreboard flags any beat
		repeat (IDLE_CYCLES) @(posedge clk);

		// no stages, 3x
		x = make_series(0, 508, 1, 254, 255, 100);
		mode = '{inv_en: 1'b0, sort_en: 1'b0};
		drive_series(x, mode, 0);

		// inverse only
		x = make_series(1, 508, 2, 3, 400, 0);
		check_inverse_model(x);
		mode = '{inv_en: 1'b1, sort_en: 1'b0};
		drive_series(x, mode, 0);

		// sort only, with duplicates
		x = make_series(17, 300, 17, 508, 0, 300);
		mode = '{inv_en: 1'b0, sort_en: 1'b1};
		drive_series(x, mode, 0);

		// both stages, junk beats during processing
		x = make_series(5, 1, 508, 200, 0, 77);
		mode = '{inv_en: 1'b1, sort_en: 1'b1};
		drive_series(x, mode, BUSY_BEATS);

		for (int n = 0; n < RANDOM_RUNS; n++) begin
			for (int k = 0; k < `SP_LEN; k++)
				x[k] = residue_t'($urandom_range(508));
			mode = sp_mode_t'($urandom_range(3));
			drive_series(x, mode, 0);
		end

		// trailing idle, stray beats still get caught
		repeat (20) @(posedge clk);
		if (exp_q.size() == 0 && runs_done == expected_runs) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("run ended with %0d series still pending", exp_q.size());
			fail_run();
		end
	end

endmodule

//--- sp_top.f
+incdir+hw
+incdir+bench
hw/sp_pkg.sv
hw/mod509_reduce.sv
hw/mod_inverse.sv
hw/series_sorter.sv
hw/sp_top.sv
bench/sp_tb.sv

//--- Makefile
# Verilator build and run for the series processor

VERILATOR ?= verilator
TOP       ?= sp_tb
FILELIST  ?= sp_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTS PASSED
VFLAGS    ?= --binary --timing -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard hw/*.sv hw/*.svh bench/*.sv bench/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides, not the exit status of the run
test: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
